// File: Makefile
TOP = tb_hs32_decode

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
rtl/hs32_isa_pkg.sv
rtl/hs32_ctl_pkg.sv
rtl/hs32_op_table.sv
rtl/hs32_decode_reg.sv
rtl/hs32_decode.sv
sim/hs32_decode_asserts.sv
sim/tb_hs32_decode.sv

// File: rtl/hs32_ctl_pkg.sv
// HS32 execute-side definitions
// ALU operation codes, write-back and operand-source modes, the control
// word and the decoded bundle handed from decode to execute

`default_nettype none

package hs32_ctl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_ADC = 4'h1,
        ALU_SUB = 4'h2,
        ALU_SBC = 4'h3,
        ALU_AND = 4'h4,
        ALU_NOT = 4'h5,  // Bit clear, Rm & ~op
        ALU_OR  = 4'h6,
        ALU_XOR = 4'h7,
        ALU_MOV = 4'h8
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_NONE  = 2'b00,  // Flags only
        WB_REG   = 2'b01,
        WB_LOAD  = 2'b10,
        WB_STORE = 2'b11
    } wb_mode_t;

    // Where execute takes its operands from
    typedef enum logic [2:0] {
        SRC_NONE    = 3'd0,
        SRC_IMM     = 3'd1,  // imm alone
        SRC_RM_IMM  = 3'd2,  // Rm with imm
        SRC_RM_SHRN = 3'd3,  // Rm with sh(Rn)
        SRC_SHRN    = 3'd4,  // sh(Rn) alone
        SRC_ST_IMM  = 3'd5,  // Store address Rm + imm
        SRC_ST_SHRN = 3'd6   // Store address Rm + sh(Rn)
    } src_mode_t;

    typedef struct packed {
        wb_mode_t   wb_mode;
        logic       reverse;    // Swap operands for RSUB forms
        src_mode_t  src_mode;
        logic       set_flags;
        logic       bank_dst;   // Rd is in the selected bank
        logic [1:0] shift_dir;
        logic       banked;     // MOV through a register bank
    } ctl_t;

    typedef struct packed {
        alu_op_t                 aluop;
        hs32_isa_pkg::shamt_t   shift;
        hs32_isa_pkg::imm_t     imm;
        hs32_isa_pkg::reg_idx_t rd;
        hs32_isa_pkg::reg_idx_t rm;
        hs32_isa_pkg::reg_idx_t rn;
        hs32_isa_pkg::bank_t    bank;
        ctl_t                    ctl;
    } dec_t;

endpackage

`default_nettype wire

// File: rtl/hs32_decode.sv
// HS32 decode stage
// Takes an instruction word from fetch when rdyd is high and presents
// the decoded bundle to execute one cycle later with reqd

`timescale 1ns/1ps
`default_nettype none

module hs32_decode (
    input  wire                       clk,
    input  wire                       reset,
    input  wire hs32_isa_pkg::instr_t instd,
    input  wire                       rdyd,
    output logic                      reqd,
    output hs32_ctl_pkg::dec_t        dec
);
    import hs32_ctl_pkg::*;

    alu_op_t aluop;
    ctl_t    ctl_base;  // shift_dir still zero here
    logic    imm_used;
    logic    legal;

    hs32_op_table i_op_table (
        .opcode   (instd.opcode),
        .aluop    (aluop),
        .ctl_base (ctl_base),
        .imm_used (imm_used),
        .legal    (legal)
    );

    hs32_decode_reg i_decode_reg (
        .clk      (clk),
        .reset    (reset),
        .rdyd     (rdyd),
        .instd    (instd),
        .aluop    (aluop),
        .ctl_base (ctl_base),
        .imm_used (imm_used),
        .legal    (legal),
        .reqd     (reqd),
        .dec      (dec)
    );

endmodule

`default_nettype wire

// File: rtl/hs32_decode_reg.sv
// HS32 decode output register
// Slices the register fields from the word, merges the opcode table
// results and registers the bundle on each fetch-ready cycle.
// reqd follows rdyd by one cycle; the bundle holds while fetch stalls.

`timescale 1ns/1ps
`default_nettype none

module hs32_decode_reg (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        rdyd,
    input  wire hs32_isa_pkg::instr_t  instd,
    input  wire hs32_ctl_pkg::alu_op_t aluop,
    input  wire hs32_ctl_pkg::ctl_t    ctl_base,
    input  wire                        imm_used,
    input  wire                        legal,
    output logic                       reqd,
    output hs32_ctl_pkg::dec_t         dec
);
    import hs32_isa_pkg::*;
    import hs32_ctl_pkg::*;

    dec_t nxt;  // Bundle for the word at the input

    always_comb begin
        // Index fields pass through even for unknown opcodes
        nxt.rd    = instd.rd;
        nxt.rm    = instd.rm;
        nxt.rn    = instd.low[RN_MSB:RN_LSB];
        nxt.shift = instd.low[SHIFT_MSB:SHIFT_LSB];
        nxt.bank  = instd.low[BANK_MSB:BANK_LSB];
        nxt.imm   = (legal && imm_used) ? instd.low : '0;  // Zero unless an immediate form

        if (legal) begin
            nxt.aluop         = aluop;
            nxt.ctl           = ctl_base;
            nxt.ctl.shift_dir = instd.low[SHDIR_MSB:SHDIR_LSB];
        end else begin
            nxt.aluop = ALU_ADD;  // Safe bundle, nothing written
            nxt.ctl   = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reqd <= 1'b0;
            dec  <= '0;
        end else begin
            reqd <= rdyd;  // One-cycle pulse per taken word
            if (rdyd) begin
                dec <= nxt;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/hs32_isa_pkg.sv
// HS32 instruction-set definitions
// Field widths, the instruction word view, sub-field slice positions
// and the opcode map of the decoded instruction groups

`default_nettype none

package hs32_isa_pkg;

    // Field widths
    localparam int OPCODE_W  = 8;
    localparam int REG_IDX_W = 4;
    localparam int IMM_W     = 16;
    localparam int SHAMT_W   = 5;
    localparam int BANK_W    = 2;
    localparam int SHDIR_W   = 2;

    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [SHAMT_W-1:0]   shamt_t;
    typedef logic [BANK_W-1:0]    bank_t;

    // One instruction word. The low half is either an immediate or the
    // Rn/shift/direction/bank overlay, so it stays one field here.
    typedef struct packed {
        opcode_t  opcode;  // 31:24
        reg_idx_t rd;      // 23:20
        reg_idx_t rm;      // 19:16
        imm_t     low;     // 15:0
    } instr_t;

    // Sub-field positions inside instr_t.low
    localparam int RN_LSB    = 12;
    localparam int RN_MSB    = RN_LSB + REG_IDX_W - 1;
    localparam int SHIFT_LSB = 11;
    localparam int SHIFT_MSB = SHIFT_LSB + SHAMT_W - 1;
    localparam int SHDIR_LSB = 9;
    localparam int SHDIR_MSB = SHDIR_LSB + SHDIR_W - 1;
    localparam int BANK_LSB  = 7;
    localparam int BANK_MSB  = BANK_LSB + BANK_W - 1;

    // Loads
    localparam opcode_t OP_LDRI   = 8'h10;  // Rd <- [Rm + imm]
    localparam opcode_t OP_LDR    = 8'h14;  // Rd <- [Rm]
    localparam opcode_t OP_LDRA   = 8'h18;  // Rd <- [Rm + sh(Rn)]

    // Register moves
    localparam opcode_t OP_MOVN   = 8'h20;  // Rd <- sh(Rn)
    localparam opcode_t OP_MOV    = 8'h21;  // Rd <- Rm_b
    localparam opcode_t OP_MOVR   = 8'h22;  // Rd_b <- Rm
    localparam opcode_t OP_MOVI   = 8'h24;  // Rd <- imm

    // Stores
    localparam opcode_t OP_STRI   = 8'h30;  // [Rm + imm] <- Rd
    localparam opcode_t OP_STR    = 8'h34;  // [Rm] <- Rd
    localparam opcode_t OP_STRA   = 8'h38;  // [Rm + sh(Rn)] <- Rd

    // Arithmetic, shifted register operand
    localparam opcode_t OP_ADD    = 8'h40;
    localparam opcode_t OP_ADDC   = 8'h41;
    localparam opcode_t OP_SUB    = 8'h42;
    localparam opcode_t OP_RSUB   = 8'h43;  // sh(Rn) - Rm
    localparam opcode_t OP_SUBC   = 8'h4A;
    localparam opcode_t OP_RSUBC  = 8'h4B;

    // Arithmetic, immediate operand
    localparam opcode_t OP_ADDI   = 8'h60;
    localparam opcode_t OP_ADDIC  = 8'h61;
    localparam opcode_t OP_SUBI   = 8'h62;
    localparam opcode_t OP_RSUBI  = 8'h63;  // imm - Rm
    localparam opcode_t OP_SUBIC  = 8'h6A;
    localparam opcode_t OP_RSUBIC = 8'h6B;

    // Logic, register then immediate operand
    localparam opcode_t OP_AND    = 8'h80;
    localparam opcode_t OP_BIC    = 8'h81;
    localparam opcode_t OP_OR     = 8'h82;
    localparam opcode_t OP_XOR    = 8'h83;
    localparam opcode_t OP_ANDI   = 8'h90;
    localparam opcode_t OP_BICI   = 8'h91;
    localparam opcode_t OP_ORI    = 8'h92;
    localparam opcode_t OP_XORI   = 8'h93;

    // Compares and tests, flags only
    localparam opcode_t OP_CMP    = 8'hC0;
    localparam opcode_t OP_CMPI   = 8'hC1;
    localparam opcode_t OP_TST    = 8'hC2;
    localparam opcode_t OP_TSTI   = 8'hC3;

endpackage

`default_nettype wire

// File: rtl/hs32_op_table.sv
// HS32 opcode table
// Maps an opcode byte to its ALU operation, control word and immediate
// use. Purely combinational; unknown opcodes report legal low.

`timescale 1ns/1ps
`default_nettype none

module hs32_op_table (
    input  wire hs32_isa_pkg::opcode_t opcode,
    output hs32_ctl_pkg::alu_op_t      aluop,
    output hs32_ctl_pkg::ctl_t         ctl_base,
    output logic                       imm_used,
    output logic                       legal
);
    import hs32_isa_pkg::*;
    import hs32_ctl_pkg::*;

    typedef struct packed {
        alu_op_t aluop;
        ctl_t    ctl;
        logic    imm_used;
    } entry_t;

    // Control word with shift direction left for the register stage
    function automatic ctl_t mk_ctl(
        input wb_mode_t  wb,
        input logic      rev,
        input src_mode_t src,
        input logic      flags,
        input logic      bdst,
        input logic      bnk
    );
        return '{wb_mode: wb, reverse: rev, src_mode: src, set_flags: flags,
                 bank_dst: bdst, shift_dir: 2'b00, banked: bnk};
    endfunction

    function automatic entry_t row(input alu_op_t op, input ctl_t c, input logic imm);
        return '{aluop: op, ctl: c, imm_used: imm};
    endfunction

    // Memory access, address always Rm based
    localparam ctl_t CTL_LD_IMM  = mk_ctl(WB_LOAD, 1'b0, SRC_RM_IMM, 1'b0, 1'b0, 1'b0);
    localparam ctl_t CTL_LD_SH   = mk_ctl(WB_LOAD, 1'b0, SRC_RM_SHRN, 1'b0, 1'b0, 1'b0);
    localparam ctl_t CTL_ST_IMM  = mk_ctl(WB_STORE, 1'b0, SRC_ST_IMM, 1'b0, 1'b0, 1'b0);
    localparam ctl_t CTL_ST_SH   = mk_ctl(WB_STORE, 1'b0, SRC_ST_SHRN, 1'b0, 1'b0, 1'b0);

    // Moves never touch flags
    localparam ctl_t CTL_MOV_IMM = mk_ctl(WB_REG, 1'b0, SRC_IMM, 1'b0, 1'b0, 1'b0);
    localparam ctl_t CTL_MOV_SH  = mk_ctl(WB_REG, 1'b0, SRC_SHRN, 1'b0, 1'b0, 1'b0);
    localparam ctl_t CTL_MOV_BRM = mk_ctl(WB_REG, 1'b0, SRC_RM_IMM, 1'b0, 1'b0, 1'b1);
    localparam ctl_t CTL_MOV_BRD = mk_ctl(WB_REG, 1'b0, SRC_RM_IMM, 1'b0, 1'b1, 1'b1);

    // Data processing writes Rd and sets flags
    localparam ctl_t CTL_ALU_REG = mk_ctl(WB_REG, 1'b0, SRC_RM_SHRN, 1'b1, 1'b0, 1'b0);
    localparam ctl_t CTL_ALU_IMM = mk_ctl(WB_REG, 1'b0, SRC_RM_IMM, 1'b1, 1'b0, 1'b0);
    localparam ctl_t CTL_RSB_REG = mk_ctl(WB_REG, 1'b1, SRC_RM_SHRN, 1'b1, 1'b0, 1'b0);
    localparam ctl_t CTL_RSB_IMM = mk_ctl(WB_REG, 1'b1, SRC_RM_IMM, 1'b1, 1'b0, 1'b0);
    localparam ctl_t CTL_CMP_REG = mk_ctl(WB_NONE, 1'b0, SRC_RM_SHRN, 1'b1, 1'b0, 1'b0);
    localparam ctl_t CTL_CMP_IMM = mk_ctl(WB_NONE, 1'b0, SRC_RM_IMM, 1'b1, 1'b0, 1'b0);

    entry_t ent;

    always_comb begin
        legal = 1'b1;
        case (opcode)
            OP_LDRI:   ent = row(ALU_ADD, CTL_LD_IMM, 1'b1);
            OP_LDR:    ent = row(ALU_ADD, CTL_LD_IMM, 1'b0);  // Offset forced to zero
            OP_LDRA:   ent = row(ALU_ADD, CTL_LD_SH, 1'b0);
            OP_STRI:   ent = row(ALU_ADD, CTL_ST_IMM, 1'b1);
            OP_STR:    ent = row(ALU_ADD, CTL_ST_IMM, 1'b0);
            OP_STRA:   ent = row(ALU_ADD, CTL_ST_SH, 1'b0);

            OP_MOVI:   ent = row(ALU_MOV, CTL_MOV_IMM, 1'b1);
            OP_MOVN:   ent = row(ALU_MOV, CTL_MOV_SH, 1'b0);
            OP_MOV:    ent = row(ALU_MOV, CTL_MOV_BRM, 1'b0);  // Read banked Rm
            OP_MOVR:   ent = row(ALU_MOV, CTL_MOV_BRD, 1'b0);  // Write banked Rd

            OP_ADD:    ent = row(ALU_ADD, CTL_ALU_REG, 1'b0);
            OP_ADDC:   ent = row(ALU_ADC, CTL_ALU_REG, 1'b0);
            OP_SUB:    ent = row(ALU_SUB, CTL_ALU_REG, 1'b0);
            OP_RSUB:   ent = row(ALU_SUB, CTL_RSB_REG, 1'b0);
            OP_SUBC:   ent = row(ALU_SBC, CTL_ALU_REG, 1'b0);
            OP_RSUBC:  ent = row(ALU_SBC, CTL_RSB_REG, 1'b0);

            OP_ADDI:   ent = row(ALU_ADD, CTL_ALU_IMM, 1'b1);
            OP_ADDIC:  ent = row(ALU_ADC, CTL_ALU_IMM, 1'b1);
            OP_SUBI:   ent = row(ALU_SUB, CTL_ALU_IMM, 1'b1);
            OP_RSUBI:  ent = row(ALU_SUB, CTL_RSB_IMM, 1'b1);
            OP_SUBIC:  ent = row(ALU_SBC, CTL_ALU_IMM, 1'b1);
            OP_RSUBIC: ent = row(ALU_SBC, CTL_RSB_IMM, 1'b1);

            OP_AND:    ent = row(ALU_AND, CTL_ALU_REG, 1'b0);
            OP_BIC:    ent = row(ALU_NOT, CTL_ALU_REG, 1'b0);
            OP_OR:     ent = row(ALU_OR, CTL_ALU_REG, 1'b0);
            OP_XOR:    ent = row(ALU_XOR, CTL_ALU_REG, 1'b0);
            OP_ANDI:   ent = row(ALU_AND, CTL_ALU_IMM, 1'b1);
            OP_BICI:   ent = row(ALU_NOT, CTL_ALU_IMM, 1'b1);
            OP_ORI:    ent = row(ALU_OR, CTL_ALU_IMM, 1'b1);
            OP_XORI:   ent = row(ALU_XOR, CTL_ALU_IMM, 1'b1);

            OP_CMP:    ent = row(ALU_SUB, CTL_CMP_REG, 1'b0);
            OP_CMPI:   ent = row(ALU_SUB, CTL_CMP_IMM, 1'b1);
            OP_TST:    ent = row(ALU_AND, CTL_CMP_REG, 1'b0);
            OP_TSTI:   ent = row(ALU_AND, CTL_CMP_IMM, 1'b1);

            default: begin
                ent   = row(ALU_ADD, '0, 1'b0);  // No write-back, no flags
                legal = 1'b0;
            end
        endcase
    end

    assign aluop    = ent.aluop;
    assign ctl_base = ent.ctl;
    assign imm_used = ent.imm_used;

endmodule

`default_nettype wire

// File: sim/hs32_decode_asserts.sv
// Decode stage protocol checks
// reqd follows rdyd by one cycle, and a store never carries a banked Rd

`timescale 1ns/1ps
`default_nettype none

module hs32_decode_asserts (
    input wire                     clk,
    input wire                     reset,
    input wire                     rdyd,
    input wire                     reqd,
    input wire hs32_ctl_pkg::dec_t dec
);
    import hs32_ctl_pkg::*;

    // First edge after reset has no valid previous rdyd
    req_follows_rdy: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> reqd == $past(rdyd))
        else $error("reqd differs from rdyd of the previous cycle");

    store_not_banked: assert property (@(posedge clk) disable iff (reset)
        !(dec.ctl.wb_mode == WB_STORE && dec.ctl.bank_dst))
        else $error("store decoded with a banked destination");

endmodule

bind hs32_decode hs32_decode_asserts i_asserts (
    .clk   (clk),
    .reset (reset),
    .rdyd  (rdyd),
    .reqd  (reqd),
    .dec   (dec)
);

`default_nettype wire

// File: sim/tb_hs32_decode.sv
// Testbench for the HS32 decode stage
// Drives instruction words with random fields, predicts each decoded
// bundle from the instruction-set rules and checks the DUT in order

`timescale 1ns/1ps
`default_nettype none

module tb_hs32_decode;
    import hs32_isa_pkg::*;
    import hs32_ctl_pkg::*;

    localparam int N_KEPT      = 34;
    localparam int STALL_WORDS = 6;
    localparam int STALL_GAP   = 3;
    localparam int STREAM_LEN  = 200;
    localparam int STIM_CYCLES = 10 + 5 + N_KEPT + 10 + STALL_WORDS * (STALL_GAP + 1)
                                 + STREAM_LEN + 5 * 4;  // Last term covers draining
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 50;

    localparam opcode_t KEPT_OPS [N_KEPT] = '{
        OP_LDRI, OP_LDR, OP_LDRA, OP_MOVN, OP_MOV, OP_MOVR, OP_MOVI, OP_STRI,
        OP_STR, OP_STRA, OP_ADD, OP_ADDC, OP_SUB, OP_RSUB, OP_SUBC, OP_RSUBC,
        OP_ADDI, OP_ADDIC, OP_SUBI, OP_RSUBI, OP_SUBIC, OP_RSUBIC, OP_AND, OP_BIC,
        OP_OR, OP_XOR, OP_ANDI, OP_BICI, OP_ORI, OP_XORI, OP_CMP, OP_CMPI,
        OP_TST, OP_TSTI
    };

    logic        clk;
    logic        reset;
    instr_t      instd;
    logic        rdyd;
    logic        reqd;
    dec_t        dec;

    dec_t        exp_q [$];  // Bundles still owed by the DUT
    dec_t        held;       // What dec must show while reqd is low
    logic        taken;      // rdyd seen at the last edge
    logic [15:0] lfsr;
    string       cur_test;
    int          errors;
    int          checks;
    int          pulses;
    int          cycles;
    int          tests;

    hs32_decode i_hs32_decode (
        .clk   (clk),
        .reset (reset),
        .instd (instd),
        .rdyd  (rdyd),
        .reqd  (reqd),
        .dec   (dec)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Galois step, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};  // One step per bit
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic logic is_kept(input opcode_t op);
        logic [5:0] k;
        for (int i = 0; i < N_KEPT; i++) begin
            k = 6'(i);
            if (KEPT_OPS[k] == op) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic instr_t word_with(input opcode_t op);
        instr_t w;
        w = instr_t'(rand_bits(32));
        w.opcode = op;
        return w;
    endfunction

    // Expected bundle for one word
    function automatic dec_t ref_decode(input instr_t w);
        dec_t       d;
        logic [3:0] grp;
        logic       imm_form;
        d = '0;
        grp = w.opcode[7:4];
        d.rd    = w.rd;  // Index fields always copied
        d.rm    = w.rm;
        d.rn    = w.low[15:12];
        d.shift = w.low[15:11];
        d.bank  = w.low[8:7];
        d.aluop = ALU_ADD;
        if (!is_kept(w.opcode)) begin
            return d;  // Safe bundle
        end
        imm_form = (w.opcode inside {OP_LDRI, OP_STRI, OP_MOVI, OP_CMPI, OP_TSTI})
                   || grp == 4'h6 || grp == 4'h9;
        d.imm = imm_form ? w.low : '0;
        d.ctl.shift_dir = w.low[10:9];
        d.ctl.set_flags = grp >= 4'h4;  // Arithmetic, logic, compares
        d.ctl.reverse   = w.opcode inside {OP_RSUB, OP_RSUBC, OP_RSUBI, OP_RSUBIC};
        d.ctl.banked    = w.opcode inside {OP_MOV, OP_MOVR};
        d.ctl.bank_dst  = w.opcode == OP_MOVR;
        d.ctl.wb_mode   = WB_REG;
        d.ctl.src_mode  = imm_form ? SRC_RM_IMM : SRC_RM_SHRN;
        case (grp)
            4'h1: begin
                d.ctl.wb_mode  = WB_LOAD;
                d.ctl.src_mode = (w.opcode == OP_LDRA) ? SRC_RM_SHRN : SRC_RM_IMM;
            end
            4'h3: begin
                d.ctl.wb_mode  = WB_STORE;
                d.ctl.src_mode = (w.opcode == OP_STRA) ? SRC_ST_SHRN : SRC_ST_IMM;
            end
            4'h2: begin
                d.ctl.src_mode = (w.opcode == OP_MOVI) ? SRC_IMM :
                                 (w.opcode == OP_MOVN) ? SRC_SHRN : SRC_RM_IMM;
            end
            4'hC: d.ctl.wb_mode = WB_NONE;  // Flags only
            default: ;
        endcase
        case (w.opcode)
            OP_MOVI, OP_MOVN, OP_MOV, OP_MOVR:                   d.aluop = ALU_MOV;
            OP_ADDC, OP_ADDIC:                                   d.aluop = ALU_ADC;
            OP_SUB, OP_RSUB, OP_SUBI, OP_RSUBI, OP_CMP, OP_CMPI: d.aluop = ALU_SUB;
            OP_SUBC, OP_RSUBC, OP_SUBIC, OP_RSUBIC:              d.aluop = ALU_SBC;
            OP_AND, OP_ANDI, OP_TST, OP_TSTI:                    d.aluop = ALU_AND;
            OP_BIC, OP_BICI:                                     d.aluop = ALU_NOT;
            OP_OR, OP_ORI:                                       d.aluop = ALU_OR;
            OP_XOR, OP_XORI:                                     d.aluop = ALU_XOR;
            default:                                             d.aluop = ALU_ADD;
        endcase
        return d;
    endfunction

    task automatic drive(input instr_t w, input logic rdy);
        @(posedge clk);
        #1;
        instd = w;
        rdyd  = rdy;
        if (rdy) begin
            exp_q.push_back(ref_decode(w));
        end
    endtask

    task automatic drain();
        drive(instr_t'(rand_bits(32)), 1'b0);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        $display("Test %-10s %s (%0d errors)", name,
                 (errors == errs_before) ? "ok" : "FAILED", errors - errs_before);
    endtask

    always @(posedge clk) begin
        taken = rdyd && !reset;  // Inputs move 1 ns after the edge
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // Comparison at the falling edge, where DUT outputs are stable
    always @(negedge clk) begin
        dec_t want;
        if (!reset) begin
            checks++;
            assert (reqd === taken) else begin
                $display("[FAIL] %s: reqd expected %b actual %b", cur_test, taken, reqd);
                errors++;
            end
            if (reqd) begin
                pulses++;
                assert (exp_q.size() != 0) else begin
                    $display("Error in %s: reqd high with no word outstanding", cur_test);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (dec === want) else begin
                        $display("[FAIL] %s: expected %h actual %h", cur_test, want, dec);
                        errors++;
                    end
                    held = want;
                end
            end else begin
                assert (dec === held) else begin
                    $display("[FAIL] %s: held expected %h actual %h", cur_test, held, dec);
                    errors++;
                end
            end
        end
    end

    initial begin
        int         errs0;
        int         sent;
        int         pulses0;
        logic       rdy;
        logic [5:0] k;
        instr_t     w;
        opcode_t    op;
        lfsr     = 16'd5;
        errors   = 0;
        checks   = 0;
        pulses   = 0;
        cycles   = 0;
        tests    = 0;
        reset    = 1'b1;
        rdyd     = 1'b0;
        instd    = '0;
        taken    = 1'b0;
        held     = '0;

        cur_test = "reset";
        errs0 = errors;
        repeat (9) @(posedge clk);
        @(negedge clk);
        assert (reqd === 1'b0 && dec === '0) else begin
            $display("[FAIL] reset: expected reqd 0 dec %h actual reqd %b dec %h",
                     dec_t'('0), reqd, dec);
            errors++;
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (5) drive(instr_t'(rand_bits(32)), 1'b0);
        drain();
        report(cur_test, errs0);

        cur_test = "opcodes";
        errs0 = errors;
        for (int i = 0; i < N_KEPT; i++) begin
            k = 6'(i);
            drive(word_with(KEPT_OPS[k]), 1'b1);
        end
        drain();
        report(cur_test, errs0);

        cur_test = "unknown";
        errs0 = errors;
        drive(word_with(8'hA0), 1'b1);  // Former branch
        drive(word_with(8'hF0), 1'b1);  // Former interrupt
        for (int i = 0; i < 8; i++) begin
            do begin
                op = 8'(rand_bits(8));
            end while (is_kept(op));
            drive(word_with(op), 1'b1);
        end
        drain();
        report(cur_test, errs0);

        cur_test = "stall";
        errs0 = errors;
        for (int i = 0; i < STALL_WORDS; i++) begin
            k = 6'(rand_bits(6) % N_KEPT);
            drive(word_with(KEPT_OPS[k]), 1'b1);
            repeat (STALL_GAP) drive(instr_t'(rand_bits(32)), 1'b0);
        end
        drain();
        report(cur_test, errs0);

        cur_test = "stream";
        errs0 = errors;
        pulses0 = pulses;
        sent = 0;
        for (int i = 0; i < STREAM_LEN; i++) begin
            rdy = rand_bits(2) != 0;  // About one gap in four
            w = instr_t'(rand_bits(32));
            if (rand_bits(1) != 0) begin
                k = 6'(rand_bits(6) % N_KEPT);
                w.opcode = KEPT_OPS[k];
            end
            drive(w, rdy);
            if (rdy) begin
                sent++;
            end
        end
        drain();
        assert (pulses - pulses0 == sent) else begin
            $display("[FAIL] stream: expected %0d bundles actual %0d", sent, pulses - pulses0);
            errors++;
        end
        report(cur_test, errs0);

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
